// ==== include/bsc_macros.svh ====
`ifndef BSC_MACROS_SVH
`define BSC_MACROS_SVH

// Word and bit counter widths
`define BSC_XLEN     32
`define BSC_CNT_W    5

// First fetch address after reset
`define BSC_RESET_PC 32'h0000_0000

// Major opcodes in bits [6:0] of the instruction
`define BSC_OP_LUI   7'b0110111
`define BSC_OP_AUIPC 7'b0010111
`define BSC_OP_JAL   7'b1101111
`define BSC_OP_IMM   7'b0010011
`define BSC_OP_REG   7'b0110011

`endif

// ==== hw/bsc_pkg.sv ====
`default_nettype none

`include "bsc_macros.svh"

package bsc_pkg;

   typedef logic [`BSC_XLEN-1:0]  word_t;
   typedef logic [4:0]            reg_addr_t;
   typedef logic [`BSC_CNT_W-1:0] cnt_t;
   typedef logic [1:0]            bool_op_t;
   typedef logic [1:0]            rd_src_t;

   // Logic unit selector
   localparam bool_op_t BOOL_ADD = 2'b00;
   localparam bool_op_t BOOL_XOR = 2'b01;
   localparam bool_op_t BOOL_OR  = 2'b10;
   localparam bool_op_t BOOL_AND = 2'b11;

   // Write-back source
   localparam rd_src_t RD_SRC_ALU = 2'b00;
   localparam rd_src_t RD_SRC_IMM = 2'b01;
   localparam rd_src_t RD_SRC_PC  = 2'b10;

   typedef struct packed {
      logic     sub;
      bool_op_t bool_op;
      logic     op_b_imm;
      rd_src_t  rd_src;
      logic     rd_wen;
      logic     jump;
      logic     pc_rel_rd;
   } dec_ctrl_t;

   typedef enum logic [1:0] {
      ST_FETCH   = 2'd0,
      ST_RF_REQ  = 2'd1,
      ST_RF_WAIT = 2'd2,
      ST_EXEC    = 2'd3
   } seq_state_e;

endpackage

`default_nettype wire

// ==== hw/bsc_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsc_macros.svh"

module bsc_decode (
   input  wire                 clk,
   input  wire                 i_rst_n,
   input  wire bsc_pkg::word_t i_ibus_rdt,
   input  wire                 i_ibus_ack,
   input  wire                 i_cnt_en,
   output bsc_pkg::dec_ctrl_t  o_ctrl,
   output bsc_pkg::reg_addr_t  o_rs1,
   output bsc_pkg::reg_addr_t  o_rs2,
   output bsc_pkg::reg_addr_t  o_rd,
   output logic                o_imm_bit
);
   import bsc_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       alt_op;
   logic       alu_f3;
   bool_op_t   f3_bool;
   logic       writes;
   dec_ctrl_t  ctrl_d;
   word_t      imm_d;
   word_t      imm_q;

   assign opcode = i_ibus_rdt[6:0];
   assign funct3 = i_ibus_rdt[14:12];
   assign alt_op = i_ibus_rdt[30];

   // Only ADD/SUB, XOR, OR and AND are kept from the ALU groups
   assign alu_f3 = (funct3 == 3'b000) || (funct3 == 3'b100) ||
                   (funct3 == 3'b110) || (funct3 == 3'b111);

   always_comb begin
      case (funct3)
         3'b100:  f3_bool = BOOL_XOR;
         3'b110:  f3_bool = BOOL_OR;
         3'b111:  f3_bool = BOOL_AND;
         default: f3_bool = BOOL_ADD;
      endcase
   end

   always_comb begin
      ctrl_d = '0;
      writes = 1'b0;
      // I-type by default
      imm_d = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
      case (opcode)
         `BSC_OP_REG: begin
            writes         = alu_f3;
            ctrl_d.sub     = (funct3 == 3'b000) && alt_op;
            ctrl_d.bool_op = f3_bool;
            ctrl_d.rd_src  = RD_SRC_ALU;
         end
         `BSC_OP_IMM: begin
            writes          = alu_f3;
            ctrl_d.op_b_imm = 1'b1;
            ctrl_d.bool_op  = f3_bool;
            ctrl_d.rd_src   = RD_SRC_ALU;
         end
         `BSC_OP_LUI: begin
            writes        = 1'b1;
            ctrl_d.rd_src = RD_SRC_IMM;
            imm_d         = {i_ibus_rdt[31:12], 12'b0};
         end
         `BSC_OP_AUIPC: begin
            writes           = 1'b1;
            ctrl_d.rd_src    = RD_SRC_PC;
            ctrl_d.pc_rel_rd = 1'b1;
            imm_d            = {i_ibus_rdt[31:12], 12'b0};
         end
         `BSC_OP_JAL: begin
            writes        = 1'b1;
            ctrl_d.rd_src = RD_SRC_PC;
            ctrl_d.jump   = 1'b1;
            imm_d         = {{12{i_ibus_rdt[31]}}, i_ibus_rdt[19:12], i_ibus_rdt[20],
                             i_ibus_rdt[30:21], 1'b0};
         end
         default: begin
         end
      endcase
      ctrl_d.rd_wen = writes && (i_ibus_rdt[11:7] != '0);
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_ctrl <= '0;
      end else if (i_ibus_ack) begin
         o_ctrl <= ctrl_d;
      end
   end

   // Register fields and the immediate that shifts out LSB first
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_rs1 <= i_ibus_rdt[19:15];
         o_rs2 <= i_ibus_rdt[24:20];
         o_rd  <= i_ibus_rdt[11:7];
         imm_q <= imm_d;
      end else if (i_cnt_en) begin
         imm_q <= {imm_q[`BSC_XLEN-1], imm_q[`BSC_XLEN-1:1]};
      end
   end

   assign o_imm_bit = imm_q[0];

endmodule

`default_nettype wire

// ==== hw/bsc_state.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsc_macros.svh"

module bsc_state (
   input  wire           clk,
   input  wire           i_rst_n,
   input  wire           i_ibus_ack,
   input  wire           i_rf_ready,
   output logic          o_ibus_cyc,
   output logic          o_rf_start,
   output logic          o_cnt_en,
   output bsc_pkg::cnt_t o_cnt
);
   import bsc_pkg::*;

   seq_state_e state_q;
   seq_state_e state_d;
   cnt_t       cnt_q;
   logic       cnt_done;

   assign cnt_done = (cnt_q == cnt_t'(`BSC_XLEN - 1));

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_FETCH: begin
            if (i_ibus_ack) begin
               state_d = ST_RF_REQ;
            end
         end
         ST_RF_REQ: begin
            state_d = ST_RF_WAIT;
         end
         ST_RF_WAIT: begin
            if (i_rf_ready) begin
               state_d = ST_EXEC;
            end
         end
         ST_EXEC: begin
            if (cnt_done) begin
               state_d = ST_FETCH;
            end
         end
         default: begin
            state_d = ST_FETCH;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= ST_FETCH;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         // Counter restarts when the operands become available
         if (state_q == ST_RF_WAIT && i_rf_ready) begin
            cnt_q <= '0;
         end else if (state_q == ST_EXEC) begin
            cnt_q <= cnt_q + cnt_t'(1);
         end
      end
   end

   assign o_ibus_cyc = (state_q == ST_FETCH);
   assign o_rf_start = (state_q == ST_RF_REQ);
   assign o_cnt_en   = (state_q == ST_EXEC);
   assign o_cnt      = cnt_q;

endmodule

`default_nettype wire

// ==== hw/bsc_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module bsc_alu (
   input  wire                     clk,
   input  wire                     i_rst_n,
   input  wire                     i_cnt_en,
   input  wire bsc_pkg::cnt_t      i_cnt,
   input  wire bsc_pkg::dec_ctrl_t i_ctrl,
   input  wire                     i_rs1,
   input  wire                     i_rs2,
   input  wire                     i_imm_bit,
   output logic                    o_rd
);
   import bsc_pkg::*;

   logic op_b;
   logic op_b_add;
   logic carry_in;
   logic carry_q;
   logic sum;

   assign op_b     = i_ctrl.op_b_imm ? i_imm_bit : i_rs2;
   // Two's complement subtract inverts b and carries in a one
   assign op_b_add = op_b ^ i_ctrl.sub;
   assign carry_in = (i_cnt == '0) ? i_ctrl.sub : carry_q;
   assign sum      = i_rs1 ^ op_b_add ^ carry_in;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= (i_rs1 & op_b_add) | (carry_in & (i_rs1 ^ op_b_add));
      end
   end

   always_comb begin
      case (i_ctrl.bool_op)
         BOOL_XOR: o_rd = i_rs1 ^ op_b;
         BOOL_OR:  o_rd = i_rs1 | op_b;
         BOOL_AND: o_rd = i_rs1 & op_b;
         default:  o_rd = sum;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/bsc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsc_macros.svh"

module bsc_ctrl #(
   parameter bsc_pkg::word_t RESET_PC = `BSC_RESET_PC
) (
   input  wire                     clk,
   input  wire                     i_rst_n,
   input  wire                     i_cnt_en,
   input  wire bsc_pkg::cnt_t      i_cnt,
   input  wire bsc_pkg::dec_ctrl_t i_ctrl,
   input  wire                     i_imm_bit,
   output bsc_pkg::word_t          o_ibus_adr,
   output logic                    o_rd
);
   import bsc_pkg::*;

   word_t pc_q;
   logic  pc_bit;
   logic  cnt0;
   logic  four_bit;
   logic  pc4_cin;
   logic  pc4_c_q;
   logic  pc4;
   logic  pcimm_cin;
   logic  pcimm_c_q;
   logic  pcimm;
   logic  next_bit;

   assign pc_bit = pc_q[0];
   assign cnt0   = (i_cnt == '0);

   // pc + 4 with a constant one at bit 2
   assign four_bit = (i_cnt == cnt_t'(2));
   assign pc4_cin  = cnt0 ? 1'b0 : pc4_c_q;
   assign pc4      = pc_bit ^ four_bit ^ pc4_cin;

   // pc + immediate
   assign pcimm_cin = cnt0 ? 1'b0 : pcimm_c_q;
   assign pcimm     = pc_bit ^ i_imm_bit ^ pcimm_cin;

   assign next_bit = i_ctrl.jump ? pcimm : pc4;
   assign o_rd     = i_ctrl.pc_rel_rd ? pcimm : pc4;

   // PC rotates LSB first and new bits enter at the top
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_q      <= RESET_PC;
         pc4_c_q   <= 1'b0;
         pcimm_c_q <= 1'b0;
      end else if (i_cnt_en) begin
         pc_q      <= {next_bit, pc_q[`BSC_XLEN-1:1]};
         pc4_c_q   <= (pc_bit & four_bit) | (pc4_cin & (pc_bit ^ four_bit));
         pcimm_c_q <= (pc_bit & i_imm_bit) | (pcimm_cin & (pc_bit ^ i_imm_bit));
      end
   end

   assign o_ibus_adr = pc_q;

endmodule

`default_nettype wire

// ==== hw/bsc_rf_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module bsc_rf_if (
   input  wire                     clk,
   input  wire                     i_rst_n,
   input  wire                     i_rf_start,
   input  wire                     i_cnt_en,
   input  wire bsc_pkg::dec_ctrl_t i_ctrl,
   input  wire bsc_pkg::reg_addr_t i_rs1,
   input  wire bsc_pkg::reg_addr_t i_rs2,
   input  wire bsc_pkg::reg_addr_t i_rd,
   input  wire                     i_alu_rd,
   input  wire                     i_imm_bit,
   input  wire                     i_ctrl_rd,
   output logic                    o_rf_rreq,
   output bsc_pkg::reg_addr_t      o_rreg0,
   output bsc_pkg::reg_addr_t      o_rreg1,
   output logic                    o_rf_wen,
   output bsc_pkg::reg_addr_t      o_wreg,
   output logic                    o_wdata
);
   import bsc_pkg::*;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_rf_rreq <= 1'b0;
      end else begin
         o_rf_rreq <= i_rf_start;
      end
   end

   // Read addresses stay put through the whole execution
   always_ff @(posedge clk) begin
      if (i_rf_start) begin
         o_rreg0 <= i_rs1;
         o_rreg1 <= i_rs2;
      end
   end

   assign o_rf_wen = i_cnt_en & i_ctrl.rd_wen;
   assign o_wreg   = i_rd;

   always_comb begin
      case (i_ctrl.rd_src)
         RD_SRC_IMM: o_wdata = i_imm_bit;
         RD_SRC_PC:  o_wdata = i_ctrl_rd;
         default:    o_wdata = i_alu_rd;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/bsc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsc_macros.svh"

module bsc_top #(
   parameter bsc_pkg::word_t RESET_PC = `BSC_RESET_PC
) (
   input  wire                 clk,
   input  wire                 i_rst_n,
   // Instruction bus
   output bsc_pkg::word_t      o_ibus_adr,
   output logic                o_ibus_cyc,
   input  wire bsc_pkg::word_t i_ibus_rdt,
   input  wire                 i_ibus_ack,
   // Register file read port
   output logic                o_rf_rreq,
   output bsc_pkg::reg_addr_t  o_rreg0,
   output bsc_pkg::reg_addr_t  o_rreg1,
   input  wire                 i_rf_ready,
   input  wire                 i_rdata0,
   input  wire                 i_rdata1,
   // Register file write port
   output logic                o_rf_wen,
   output bsc_pkg::reg_addr_t  o_wreg,
   output logic                o_wdata
);
   import bsc_pkg::*;

   dec_ctrl_t ctrl;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t rd_addr;
   logic      imm_bit;
   logic      rf_start;
   logic      cnt_en;
   cnt_t      cnt;
   logic      alu_rd;
   logic      ctrl_rd;

   bsc_decode decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_cnt_en   (cnt_en),
      .o_ctrl     (ctrl),
      .o_rs1      (rs1_addr),
      .o_rs2      (rs2_addr),
      .o_rd       (rd_addr),
      .o_imm_bit  (imm_bit)
   );

   bsc_state state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_start (rf_start),
      .o_cnt_en   (cnt_en),
      .o_cnt      (cnt)
   );

   bsc_alu alu (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_cnt_en  (cnt_en),
      .i_cnt     (cnt),
      .i_ctrl    (ctrl),
      .i_rs1     (i_rdata0),
      .i_rs2     (i_rdata1),
      .i_imm_bit (imm_bit),
      .o_rd      (alu_rd)
   );

   bsc_ctrl #(
      .RESET_PC (RESET_PC)
   ) pc_ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_ctrl     (ctrl),
      .i_imm_bit  (imm_bit),
      .o_ibus_adr (o_ibus_adr),
      .o_rd       (ctrl_rd)
   );

   bsc_rf_if rf_if (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rf_start (rf_start),
      .i_cnt_en   (cnt_en),
      .i_ctrl     (ctrl),
      .i_rs1      (rs1_addr),
      .i_rs2      (rs2_addr),
      .i_rd       (rd_addr),
      .i_alu_rd   (alu_rd),
      .i_imm_bit  (imm_bit),
      .i_ctrl_rd  (ctrl_rd),
      .o_rf_rreq  (o_rf_rreq),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .o_rf_wen   (o_rf_wen),
      .o_wreg     (o_wreg),
      .o_wdata    (o_wdata)
   );

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD     = 10,
   parameter int RST_CYCLES = 5
) (
   output logic o_clk,
   output logic o_rst_n
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD / 2);
         o_clk = ~o_clk;
      end
   end

   // Released just after the last reset edge
   initial begin
      o_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge o_clk);
      #1;
      o_rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== tests/bsc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsc_macros.svh"

module bsc_tb;
   import bsc_pkg::*;

   localparam int TIMEOUT = 100;

   logic      clk;
   logic      rst_n;
   word_t     ibus_adr;
   logic      ibus_cyc;
   word_t     ibus_rdt;
   logic      ibus_ack;
   logic      rf_rreq;
   reg_addr_t rreg0;
   reg_addr_t rreg1;
   logic      rf_ready;
   logic      rdata0;
   logic      rdata1;
   logic      rf_wen;
   reg_addr_t wreg;
   logic      wdata;

   word_t     regs [0:31];
   word_t     imem [0:255];
   word_t     pc_model;
   integer    seed;

   tb_clk_gen clk_gen (
      .o_clk   (clk),
      .o_rst_n (rst_n)
   );

   bsc_top uut (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_rf_rreq  (rf_rreq),
      .o_rreg0    (rreg0),
      .o_rreg1    (rreg1),
      .i_rf_ready (rf_ready),
      .i_rdata0   (rdata0),
      .i_rdata1   (rdata1),
      .o_rf_wen   (rf_wen),
      .o_wreg     (wreg),
      .o_wdata    (wdata)
   );

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic compare(input string name, input word_t exp, input word_t act);
      assert (act === exp) else begin
         $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
         $display("*** FAILED ***");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic timeout_abort(input string what);
      $display("Timed out waiting for %s", what);
      $display("*** FAILED ***");
      $fatal(1, "wait loop gave up");
   endtask

   function automatic word_t r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input reg_addr_t rd, input reg_addr_t rs1,
                                         input reg_addr_t rs2);
      return {f7, rs2, rs1, f3, rd, `BSC_OP_REG};
   endfunction

   function automatic word_t i_type_word(input logic [11:0] imm, input logic [2:0] f3,
                                         input reg_addr_t rd, input reg_addr_t rs1);
      return {imm, rs1, f3, rd, `BSC_OP_IMM};
   endfunction

   function automatic word_t u_type_word(input logic [19:0] imm, input reg_addr_t rd,
                                         input logic [6:0] opcode);
      return {imm, rd, opcode};
   endfunction

   function automatic word_t j_type_word(input logic [20:0] imm, input reg_addr_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `BSC_OP_JAL};
   endfunction

   // Op index order is add, sub, xor, or, and
   function automatic logic [2:0] op_f3(input int op);
      case (op)
         2:       return 3'b100;
         3:       return 3'b110;
         4:       return 3'b111;
         default: return 3'b000;
      endcase
   endfunction

   function automatic word_t expected_alu(input int op, input word_t a, input word_t b);
      case (op)
         0:       return a + b;
         1:       return a - b;
         2:       return a ^ b;
         3:       return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic idle_bus_check();
      compare("o_ibus_cyc", 32'h1, word_t'(ibus_cyc));
      compare("o_ibus_adr", `BSC_RESET_PC, ibus_adr);
      compare("o_rf_rreq", 32'h0, word_t'(rf_rreq));
      compare("o_rf_wen", 32'h0, word_t'(rf_wen));
   endtask

   // One instruction from fetch to write-back against the serial register file
   task automatic run_instr(input word_t instr, input logic exp_wen, input word_t exp_rd_val,
                            input word_t exp_next_pc);
      int    count;
      int    lat;
      word_t op0;
      word_t op1;
      word_t result;
      imem[pc_model[9:2]] = instr;
      count = 0;
      while (!ibus_cyc) begin
         if (count == TIMEOUT) begin
            timeout_abort("instruction fetch");
         end
         next_cycle();
         count++;
      end
      compare("o_ibus_adr", pc_model, ibus_adr);
      ibus_rdt = imem[ibus_adr[9:2]];
      ibus_ack = 1'b1;
      next_cycle();
      ibus_ack = 1'b0;
      ibus_rdt = '0;
      compare("o_ibus_cyc", 32'h0, word_t'(ibus_cyc));
      count = 0;
      while (!rf_rreq) begin
         if (count == TIMEOUT) begin
            timeout_abort("register read request");
         end
         next_cycle();
         count++;
      end
      compare("o_rreg0", word_t'(instr[19:15]), word_t'(rreg0));
      compare("o_rreg1", word_t'(instr[24:20]), word_t'(rreg1));
      op0 = regs[rreg0];
      op1 = regs[rreg1];
      // Ready comes 1 to 4 cycles after the request
      lat = ($random(seed) & 3) + 1;
      repeat (lat) begin
         next_cycle();
         compare("o_rf_rreq", 32'h0, word_t'(rf_rreq));
         compare("o_rf_wen", 32'h0, word_t'(rf_wen));
      end
      rf_ready = 1'b1;
      next_cycle();
      rf_ready = 1'b0;
      result = '0;
      for (int k = 0; k < 32; k++) begin
         rdata0 = op0[k];
         rdata1 = op1[k];
         @(negedge clk);
         compare("o_rf_wen", word_t'(exp_wen), word_t'(rf_wen));
         compare("o_rreg0", word_t'(instr[19:15]), word_t'(rreg0));
         if (exp_wen) begin
            compare("o_wreg", word_t'(instr[11:7]), word_t'(wreg));
         end
         result[k] = wdata;
         next_cycle();
      end
      // Fetch resumes right after bit 31
      compare("o_ibus_cyc", 32'h1, word_t'(ibus_cyc));
      compare("o_ibus_adr", exp_next_pc, ibus_adr);
      if (exp_wen) begin
         compare("o_wdata", exp_rd_val, result);
         regs[instr[11:7]] = result;
      end
      pc_model = exp_next_pc;
   endtask

   task automatic reset_state();
      int count;
      repeat (2) @(posedge clk);
      @(negedge clk);
      idle_bus_check();
      count = 0;
      while (!rst_n) begin
         if (count == TIMEOUT) begin
            timeout_abort("reset release");
         end
         @(negedge clk);
         count++;
      end
      next_cycle();
      idle_bus_check();
   endtask

   task automatic alu_reg_ops(input int rounds);
      word_t     a;
      word_t     b;
      word_t     r;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      for (int n = 0; n < rounds; n++) begin
         for (int op = 0; op < 5; op++) begin
            a   = $random(seed);
            b   = $random(seed);
            r   = $random(seed);
            rs1 = reg_addr_t'(r[2:0]) + 5'd1;
            rs2 = reg_addr_t'(r[5:3]) + 5'd9;
            rd  = (r[10:6] == 5'd0) ? 5'd1 : r[10:6];
            regs[rs1] = a;
            regs[rs2] = b;
            run_instr(r_type_word((op == 1) ? 7'h20 : 7'h00, op_f3(op), rd, rs1, rs2), 1'b1,
                      expected_alu(op, a, b), pc_model + 4);
         end
      end
   endtask

   task automatic alu_imm_ops(input int rounds);
      word_t       a;
      word_t       r;
      logic [11:0] imm;
      reg_addr_t   rs1;
      reg_addr_t   rd;
      for (int n = 0; n < rounds; n++) begin
         for (int op = 0; op < 5; op++) begin
            // No immediate form of sub
            if (op != 1) begin
               a   = $random(seed);
               r   = $random(seed);
               imm = r[22:11];
               rs1 = reg_addr_t'(r[2:0]) + 5'd1;
               rd  = (r[10:6] == 5'd0) ? 5'd2 : r[10:6];
               regs[rs1] = a;
               run_instr(i_type_word(imm, op_f3(op), rd, rs1), 1'b1,
                         expected_alu(op, a, {{20{imm[11]}}, imm}), pc_model + 4);
            end
         end
      end
   endtask

   task automatic upper_imm_ops(input int rounds);
      word_t     r;
      word_t     upper;
      reg_addr_t rd;
      for (int n = 0; n < rounds; n++) begin
         r     = $random(seed);
         rd    = (r[4:0] == 5'd0) ? 5'd31 : r[4:0];
         upper = {r[31:12], 12'h000};
         run_instr(u_type_word(r[31:12], rd, `BSC_OP_LUI), 1'b1, upper, pc_model + 4);
         run_instr(u_type_word(r[31:12], rd, `BSC_OP_AUIPC), 1'b1, pc_model + upper,
                   pc_model + 4);
      end
   endtask

   task automatic jump_op(input int rounds);
      word_t       r;
      reg_addr_t   rd;
      logic [20:0] offset;
      for (int n = 0; n < rounds; n++) begin
         r      = $random(seed);
         rd     = (r[25:21] == 5'd0) ? 5'd1 : r[25:21];
         offset = {r[20:2], 2'b00};
         run_instr(j_type_word(offset, rd), 1'b1, pc_model + 4,
                   pc_model + {{11{offset[20]}}, offset});
      end
   endtask

   task automatic no_write_ops();
      run_instr(i_type_word(12'h7ff, 3'b000, 5'd0, 5'd3), 1'b0, '0, pc_model + 4);
      run_instr(r_type_word(7'h00, 3'b000, 5'd0, 5'd1, 5'd2), 1'b0, '0, pc_model + 4);
      // Load and store opcodes are not decoded
      run_instr({12'h004, 5'd1, 3'b010, 5'd7, 7'b0000011}, 1'b0, '0, pc_model + 4);
      run_instr({7'h00, 5'd2, 5'd1, 3'b010, 5'd4, 7'b0100011}, 1'b0, '0, pc_model + 4);
   endtask

   initial begin
      seed     = 32'h928e5e2f;
      ibus_rdt = '0;
      ibus_ack = 1'b0;
      rf_ready = 1'b0;
      rdata0   = 1'b0;
      rdata1   = 1'b0;
      pc_model = `BSC_RESET_PC;
      // x0 comes out as zero
      for (int i = 0; i < 32; i++) begin
         regs[i] = word_t'(i) * 32'h9E37_79B9;
      end
      reset_state();
      alu_reg_ops(4);
      alu_imm_ops(4);
      upper_imm_ops(3);
      jump_op(4);
      no_write_ops();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hw/bsc_pkg.sv
hw/bsc_decode.sv
hw/bsc_state.sv
hw/bsc_alu.sv
hw/bsc_ctrl.sv
hw/bsc_rf_if.sv
hw/bsc_top.sv
tests/tb_clk_gen.sv
tests/bsc_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module bsc_tb -f sources.f -o bsc_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/bsc_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** PASSED ***'; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
